// File: hw/pic_pkg.sv
// Shared widths, command bit positions and enums for the 8-level PIC; edge mode and ICW4 are not modelled
package pic_pkg;

    // Sizes of the controller
    localparam int num_levels        = 8;                         // Interrupt request inputs
    localparam int level_width       = 3;                         // Level index and cascade ID
    localparam int data_width        = 8;                         // CPU bus byte
    localparam int vector_base_width = data_width - level_width;  // Upper vector bits from ICW2
    localparam int op_width          = 3;                         // OCW2 opcode field

    // Command byte layout
    localparam int icw1_flag_bit  = 4;  // Set for ICW1, clear for OCW2 when a0 is low
    localparam int ocw2_op_lsb    = 5;  // Opcode sits in bits 7 down to 5
    localparam int ocw2_level_lsb = 0;  // EOI level sits in bits 2 down to 0

    // Initialization sequence
    typedef enum logic [1:0] {
        init_idle,        // Waiting for ICW1
        init_wait_icw2,   // Next a0 write is the vector base
        init_wait_icw3,   // Next a0 write is the cascade byte
        init_ready        // Taking OCW1 and OCW2
    } init_state_t;

    // OCW2 commands that this model acts on
    typedef enum logic [op_width-1:0] {
        op_none            = 3'd0,
        op_nonspecific_eoi = 3'd1,  // Clear highest in-service level
        op_specific_eoi    = 3'd3   // Clear the level given in the byte
    } ocw2_op_t;

    // Two-pulse acknowledge
    typedef enum logic {
        ack_idle,         // Next inta is the first pulse
        ack_wait_second   // Level latched, waiting for vector pulse
    } ack_state_t;

endpackage

// File: hw/pic_config_regs.sv
// ICW1 always restarts init and clears the mask; writes other than ICW1 are ignored until ICW3 is taken
`timescale 1ns/1ps

module pic_config_regs
    import pic_pkg::*;
(
    input  logic                         control_signal,
    input  logic                         reset,
    input  logic                         wr,            // One-cycle write strobe
    input  logic                         a0,            // Command address bit
    input  logic [data_width-1:0]        data_in,
    output logic [vector_base_width-1:0] vector_base,
    output logic [data_width-1:0]        cascade_byte,  // Slave mask or own ID
    output logic [num_levels-1:0]        imr,
    output logic                         ready,
    output logic                         eoi_valid,     // Pulse in cycle after OCW2
    output ocw2_op_t                     eoi_op,
    output logic [level_width-1:0]       eoi_level
);

    init_state_t state;
    ocw2_op_t    op_raw;     // Opcode field of the current byte
    ocw2_op_t    op_decoded; // Only the supported EOI commands survive
    logic        is_icw1;
    logic        is_ocw2;

    assign is_icw1 = wr && !a0 && data_in[icw1_flag_bit];
    assign is_ocw2 = wr && !a0 && !data_in[icw1_flag_bit] && (state == init_ready);
    assign op_raw  = ocw2_op_t'(data_in[ocw2_op_lsb +: op_width]);
    assign ready   = (state == init_ready);

    always_comb begin
        case (op_raw)
            op_nonspecific_eoi: op_decoded = op_nonspecific_eoi;
            op_specific_eoi:    op_decoded = op_specific_eoi;
            default:            op_decoded = op_none;  // Rotate and mask commands dropped
        endcase
    end

    // Init FSM and mask register
    always_ff @(posedge control_signal) begin
        if (reset) begin
            state        <= init_idle;
            imr          <= '1;              // Everything masked until ICW1
            cascade_byte <= '0;              // No slaves, ID 0
        end else if (is_icw1) begin
            state        <= init_wait_icw2;  // Restart from any state
            imr          <= '0;
        end else if (wr && a0) begin
            case (state)
                init_wait_icw2: state <= init_wait_icw3;
                init_wait_icw3: begin
                    state        <= init_ready;
                    cascade_byte <= data_in;
                end
                init_ready:     imr <= data_in;    // OCW1
                default:        state <= state;    // No ICW1 yet
            endcase
        end
    end

    // Vector base from ICW2
    always_ff @(posedge control_signal) begin
        if (wr && a0 && (state == init_wait_icw2)) begin
            vector_base <= data_in[data_width-1 -: vector_base_width];
        end
    end

    // Pending EOI command, one cycle after the OCW2 write
    always_ff @(posedge control_signal) begin
        if (reset) begin
            eoi_valid <= 1'b0;
        end else begin
            eoi_valid <= is_ocw2 && (op_decoded != op_none);
        end
    end

    always_ff @(posedge control_signal) begin
        if (is_ocw2) begin
            eoi_op    <= op_decoded;
            eoi_level <= data_in[ocw2_level_lsb +: level_width];
        end
    end

    // An EOI pulse must come from a write taken while initialized
    eoi_only_when_ready: assert property (
        @(posedge control_signal) disable iff (reset)
        eoi_valid |-> (state == init_ready)
    );

endmodule

// File: hw/pic_priority_resolver.sv
// Level triggered, fixed priority with level 0 highest; no rotation, special mask or polling
`timescale 1ns/1ps

module pic_priority_resolver
    import pic_pkg::*;
(
    input  logic                   control_signal,
    input  logic                   reset,
    input  logic [num_levels-1:0]  ir,            // Raw request lines
    input  logic [num_levels-1:0]  imr,
    input  logic                   ready,         // Init done
    input  logic                   commit,        // Put commit_level in service
    input  logic [level_width-1:0] commit_level,
    input  logic                   eoi_valid,
    input  ocw2_op_t               eoi_op,
    input  logic [level_width-1:0] eoi_level,
    output logic [level_width-1:0] best_level,    // Highest unmasked request
    output logic                   int_req
);

    logic [num_levels-1:0]  irr;          // Sampled requests
    logic [num_levels-1:0]  isr;          // In-service levels
    logic [num_levels-1:0]  isr_next;
    logic [num_levels-1:0]  pending;      // Requests passing the mask
    logic [level_width-1:0] isr_top;      // Highest level in service
    logic                   int_req_next;

    // Index of the lowest set bit, 0 when empty
    function automatic logic [level_width-1:0] lowest_set(input logic [num_levels-1:0] vec);
        logic [level_width-1:0] idx;
        idx = '0;
        for (int i = num_levels - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = level_width'(i);  // Lower index wins, so scan downward
            end
        end
        return idx;
    endfunction

    assign pending    = irr & ~imr;
    assign best_level = lowest_set(pending);
    assign isr_top    = lowest_set(isr);

    // Request only if it outranks everything in service
    assign int_req_next = ready && (pending != '0) && ((isr == '0) || (best_level < isr_top));

    // EOI clears first, then a commit in the same cycle sets
    always_comb begin
        isr_next = isr;
        if (eoi_valid) begin
            case (eoi_op)
                op_nonspecific_eoi: begin
                    if (isr != '0) begin
                        isr_next[isr_top] = 1'b0;
                    end
                end
                op_specific_eoi:    isr_next[eoi_level] = 1'b0;
                default:            isr_next = isr;
            endcase
        end
        if (commit) begin
            isr_next[commit_level] = 1'b1;
        end
    end

    always_ff @(posedge control_signal) begin
        if (reset) begin
            irr     <= '0;
            isr     <= '0;
            int_req <= 1'b0;
        end else begin
            irr     <= ir;            // Level mode, follows the pins
            isr     <= isr_next;
            int_req <= int_req_next;  // Second stage of the ir to int_req path
        end
    end

    // Acknowledge sequencer must only commit a level that is requesting
    commit_names_request: assert property (
        @(posedge control_signal) disable iff (reset)
        commit |-> irr[commit_level]
    );

endmodule

// File: hw/pic_cascade_controller.sv
// Master drives cas_out only for levels marked in ICW3; slave ID compare happens at the second inta only
`timescale 1ns/1ps

module pic_cascade_controller
    import pic_pkg::*;
(
    input  logic                   control_signal,
    input  logic                   reset,
    input  logic                   sp,             // High for master
    input  logic [data_width-1:0]  cascade_byte,   // ICW3 contents
    input  logic [level_width-1:0] ack_level,      // Level under acknowledge
    input  logic                   first_ack,
    input  logic                   second_ack,
    input  logic [level_width-1:0] cas_in,
    output logic [level_width-1:0] cas_out,
    output logic                   cas_oe,
    output logic                   vector_enable   // This device owns the vector
);

    logic [level_width-1:0] slave_id;   // Own ID in slave mode
    logic                   id_match;
    logic                   cascaded;   // Level has a slave behind it

    assign slave_id = cascade_byte[level_width-1:0];
    assign id_match = (cas_in == slave_id);
    assign cascaded = cascade_byte[ack_level];

    // Master supplies the vector for its own levels, slave only when addressed
    assign vector_enable = sp ? !cascaded : id_match;

    // Cascade lines live from first to second pulse
    always_ff @(posedge control_signal) begin
        if (reset) begin
            cas_oe <= 1'b0;
        end else if (second_ack) begin
            cas_oe <= 1'b0;                   // Slave has taken the bus by now
        end else if (first_ack && sp && cascaded) begin
            cas_oe <= 1'b1;
        end
    end

    // ID payload, held while cas_oe is high
    always_ff @(posedge control_signal) begin
        if (first_ack && sp && cascaded) begin
            cas_out <= ack_level;             // Slave ID equals the master level
        end
    end

    // A slave never drives the cascade lines
    no_cas_drive_in_slave: assert property (
        @(posedge control_signal) disable iff (reset)
        !sp |-> !cas_oe
    );

endmodule

// File: hw/pic_ack_sequencer.sv
// inta pulses must be one cycle wide and at least one cycle apart; no spurious level 7 handling
`timescale 1ns/1ps

module pic_ack_sequencer
    import pic_pkg::*;
(
    input  logic                         control_signal,
    input  logic                         reset,
    input  logic                         sp,            // High for master
    input  logic                         inta,          // One-cycle acknowledge strobe
    input  logic [level_width-1:0]       best_level,
    input  logic [vector_base_width-1:0] vector_base,
    input  logic                         vector_enable, // From cascade controller
    output logic [level_width-1:0]       ack_level,
    output logic                         first_ack,
    output logic                         second_ack,
    output logic                         commit,
    output logic [data_width-1:0]        data_out,
    output logic                         data_oe
);

    ack_state_t             state;
    logic [level_width-1:0] latched_level;  // Level frozen at the first pulse
    logic                   commit_master;
    logic                   commit_slave;

    assign first_ack  = inta && (state == ack_idle);
    assign second_ack = inta && (state == ack_wait_second);

    // Live level on the first pulse, frozen level after it
    assign ack_level = (state == ack_idle) ? best_level : latched_level;

    // Master commits on first pulse; slave waits for its ID to show up
    assign commit_master = first_ack && sp;
    assign commit_slave  = second_ack && !sp && vector_enable;
    assign commit        = commit_master || commit_slave;

    always_ff @(posedge control_signal) begin
        if (reset) begin
            state <= ack_idle;
        end else begin
            case (state)
                ack_idle: begin
                    if (first_ack) begin
                        state <= ack_wait_second;
                    end
                end
                ack_wait_second: begin
                    if (second_ack) begin
                        state <= ack_idle;
                    end
                end
                default: state <= ack_idle;
            endcase
        end
    end

    always_ff @(posedge control_signal) begin
        if (first_ack) begin
            latched_level <= best_level;
        end
    end

    // Vector strobe for exactly one cycle after the second pulse
    always_ff @(posedge control_signal) begin
        if (reset) begin
            data_oe <= 1'b0;
        end else begin
            data_oe <= second_ack && vector_enable;
        end
    end

    // Vector byte is base times 8 plus level
    always_ff @(posedge control_signal) begin
        if (second_ack && vector_enable) begin
            data_out <= {vector_base, ack_level};
        end
    end

endmodule

// File: hw/pic_top.sv
// Tri-state data and cascade buses are split into separate in, out and enable ports
`timescale 1ns/1ps

module pic_top
    import pic_pkg::*;
(
    input  logic                   control_signal,
    input  logic                   reset,
    input  logic                   sp,         // High for master
    input  logic                   wr,
    input  logic                   a0,
    input  logic [data_width-1:0]  data_in,
    input  logic [num_levels-1:0]  ir,
    input  logic                   inta,
    input  logic [level_width-1:0] cas_in,
    output logic [level_width-1:0] cas_out,
    output logic                   cas_oe,
    output logic                   int_req,
    output logic [data_width-1:0]  data_out,
    output logic                   data_oe
);

    logic [vector_base_width-1:0] vector_base;
    logic [data_width-1:0]        cascade_byte;
    logic [num_levels-1:0]        imr;
    logic                         ready;
    logic                         eoi_valid;
    ocw2_op_t                     eoi_op;
    logic [level_width-1:0]       eoi_level;
    logic [level_width-1:0]       best_level;
    logic [level_width-1:0]       ack_level;
    logic                         first_ack;
    logic                         second_ack;
    logic                         commit;
    logic                         vector_enable;

    pic_config_regs i_config_regs (
        .control_signal (control_signal),
        .reset          (reset),
        .wr             (wr),
        .a0             (a0),
        .data_in        (data_in),
        .vector_base    (vector_base),
        .cascade_byte   (cascade_byte),
        .imr            (imr),
        .ready          (ready),
        .eoi_valid      (eoi_valid),
        .eoi_op         (eoi_op),
        .eoi_level      (eoi_level)
    );

    pic_priority_resolver i_priority_resolver (
        .control_signal (control_signal),
        .reset          (reset),
        .ir             (ir),
        .imr            (imr),
        .ready          (ready),
        .commit         (commit),
        .commit_level   (ack_level),     // Committed level is the acknowledged one
        .eoi_valid      (eoi_valid),
        .eoi_op         (eoi_op),
        .eoi_level      (eoi_level),
        .best_level     (best_level),
        .int_req        (int_req)
    );

    pic_cascade_controller i_cascade_controller (
        .control_signal (control_signal),
        .reset          (reset),
        .sp             (sp),
        .cascade_byte   (cascade_byte),
        .ack_level      (ack_level),
        .first_ack      (first_ack),
        .second_ack     (second_ack),
        .cas_in         (cas_in),
        .cas_out        (cas_out),
        .cas_oe         (cas_oe),
        .vector_enable  (vector_enable)
    );

    pic_ack_sequencer i_ack_sequencer (
        .control_signal (control_signal),
        .reset          (reset),
        .sp             (sp),
        .inta           (inta),
        .best_level     (best_level),
        .vector_base    (vector_base),
        .vector_enable  (vector_enable),
        .ack_level      (ack_level),
        .first_ack      (first_ack),
        .second_ack     (second_ack),
        .commit         (commit),
        .data_out       (data_out),
        .data_oe        (data_oe)
    );

endmodule

// File: verif/pic_checker.sv
// Samples DUT outputs one edge after each strobe from the testbench; expected values come from the table
`timescale 1ns/1ps

module pic_checker
    import pic_pkg::*;
(
    input  logic                   control_signal,
    input  logic                   reset,
    input  logic                   sp,
    input  logic                   int_req,
    input  logic [level_width-1:0] cas_out,
    input  logic                   cas_oe,
    input  logic [data_width-1:0]  data_out,
    input  logic                   data_oe,
    input  string                  test_name,
    input  logic                   chk_irq,     // Compare int_req
    input  logic                   chk_mid,     // Compare cascade lines between pulses
    input  logic                   chk_vec,     // Compare vector strobe and byte
    input  logic                   row_done,
    input  logic                   exp_irq,
    input  logic                   exp_vv,      // Vector expected at all
    input  logic [data_width-1:0]  exp_vec,
    input  logic                   exp_oe,
    input  logic [level_width-1:0] exp_cas,
    output int                     fail_count,
    output int                     check_count
);

    int row_fails;  // Mismatches in the running row

    initial begin
        fail_count  = 0;
        check_count = 0;
        row_fails   = 0;
    end

    task automatic compare(input string what, input logic [7:0] expv, input logic [7:0] actv);
        check_count++;
        if (expv !== actv) begin
            $display("FAILED %s %s expected %0h actual %0h", test_name, what, expv, actv);
            fail_count++;
            row_fails++;
        end
    endtask

    always @(posedge control_signal) begin
        if (chk_irq) compare("int_req", 8'(exp_irq), 8'(int_req));
        if (chk_mid) begin
            compare("cas_oe", 8'(exp_oe), 8'(cas_oe));
            if (exp_oe) compare("cas_out", 8'(exp_cas), 8'(cas_out));
        end
        if (chk_vec) begin
            compare("data_oe", 8'(exp_vv), 8'(data_oe));
            if (exp_vv) compare("vector", exp_vec, data_out);
        end
        if (!reset && !sp && cas_oe) begin                  // Slave must keep off the lines
            $display("Test %s: cas_oe went high while in slave mode", test_name);
            fail_count++;
            row_fails++;
        end
        if (row_done) begin
            if (row_fails == 0) $display("Test %s: ok", test_name);
            else $display("Test %s: %0d mismatches", test_name, row_fails);
            row_fails = 0;
        end
    end

endmodule

// File: verif/pic_tb.sv
// Each table row runs writes, an ir pattern, an int_req check and an optional two-pulse inta
`timescale 1ns/1ps

module pic_tb
    import pic_pkg::*;
;

    localparam int n_rows         = 14;
    localparam int cycles_per_row = 30;                          // Reset, four writes, ack, margin
    localparam int clk_period_ns  = 20;
    localparam int watchdog_ns    = n_rows * cycles_per_row * 2 * clk_period_ns;

    logic                   control_signal;
    logic                   reset;
    logic                   sp;
    logic                   wr;
    logic                   a0;
    logic [data_width-1:0]  data_in;
    logic [num_levels-1:0]  ir;
    logic                   inta;
    logic [level_width-1:0] cas_in;
    logic [level_width-1:0] cas_out;
    logic                   cas_oe;
    logic                   int_req;
    logic [data_width-1:0]  data_out;
    logic                   data_oe;

    // Strobes and expected values for the checker
    string                  cur_name;
    logic                   chk_irq, chk_mid, chk_vec, row_done;
    logic                   exp_irq, exp_vv, exp_oe;
    logic [data_width-1:0]  exp_vec;
    logic [level_width-1:0] exp_cas;
    int                     fail_count;
    int                     check_count;

    // Stimulus table, a write entry is {a0, byte}
    string                  t_name   [n_rows];
    logic                   t_rst    [n_rows];
    logic                   t_sp     [n_rows];
    int                     t_nwr    [n_rows];
    logic [8:0]             t_wr     [n_rows][4];
    logic [num_levels-1:0]  t_ir     [n_rows];
    logic [level_width-1:0] t_cas_in [n_rows];
    logic                   t_ack    [n_rows];
    logic                   t_irq    [n_rows];
    logic                   t_vv     [n_rows];
    logic [data_width-1:0]  t_vec    [n_rows];
    logic                   t_oe     [n_rows];
    logic [level_width-1:0] t_cas    [n_rows];
    int                     row_count;

    pic_top i_dut (
        .control_signal (control_signal), .reset (reset), .sp (sp), .wr (wr), .a0 (a0),
        .data_in (data_in), .ir (ir), .inta (inta), .cas_in (cas_in), .cas_out (cas_out),
        .cas_oe (cas_oe), .int_req (int_req), .data_out (data_out), .data_oe (data_oe)
    );

    pic_checker i_checker (
        .control_signal (control_signal), .reset (reset), .sp (sp), .int_req (int_req),
        .cas_out (cas_out), .cas_oe (cas_oe), .data_out (data_out), .data_oe (data_oe),
        .test_name (cur_name), .chk_irq (chk_irq), .chk_mid (chk_mid), .chk_vec (chk_vec),
        .row_done (row_done), .exp_irq (exp_irq), .exp_vv (exp_vv), .exp_vec (exp_vec),
        .exp_oe (exp_oe), .exp_cas (exp_cas), .fail_count (fail_count),
        .check_count (check_count)
    );

    initial begin
        control_signal = 1'b0;
        forever #(clk_period_ns / 2) control_signal = ~control_signal;
    end

    task automatic add_row(input string name, input logic rst, input logic mode, input int nwr,
                           input logic [8:0] w0, input logic [8:0] w1, input logic [8:0] w2,
                           input logic [8:0] w3, input logic [7:0] irq_lines,
                           input logic [2:0] cin, input logic ack, input logic irq,
                           input logic vv, input logic [7:0] vec, input logic oe,
                           input logic [2:0] cas);
        t_name[row_count]   = name;
        t_rst[row_count]    = rst;
        t_sp[row_count]     = mode;
        t_nwr[row_count]    = nwr;
        t_wr[row_count][0]  = w0;
        t_wr[row_count][1]  = w1;
        t_wr[row_count][2]  = w2;
        t_wr[row_count][3]  = w3;
        t_ir[row_count]     = irq_lines;
        t_cas_in[row_count] = cin;
        t_ack[row_count]    = ack;
        t_irq[row_count]    = irq;
        t_vv[row_count]     = vv;
        t_vec[row_count]    = vec;
        t_oe[row_count]     = oe;
        t_cas[row_count]    = cas;
        row_count++;
    endtask

    task automatic load_table();
        logic [8:0] icw1, icw2, nseoi, seoi5, seoi2;
        icw1  = 9'h010;                                          // a0 low, flag bit set
        icw2  = 9'h140;                                          // Base field 8, vectors 0x40+
        nseoi = {1'b0, 3'(op_nonspecific_eoi), 5'd0};
        seoi5 = {1'b0, 3'(op_specific_eoi), 2'd0, 3'd5};
        seoi2 = {1'b0, 3'(op_specific_eoi), 2'd0, 3'd2};
        row_count = 0;
        add_row("master_basic", 1'b1, 1'b1, 3, icw1, icw2, 9'h100, 9'h000, 8'h24, 3'd0,
                1'b1, 1'b1, 1'b1, 8'h42, 1'b0, 3'd0);
        add_row("mask_level2", 1'b1, 1'b1, 4, icw1, icw2, 9'h100, 9'h104, 8'h24, 3'd0,
                1'b1, 1'b1, 1'b1, 8'h45, 1'b0, 3'd0);            // Leaves level 5 in service
        add_row("mask_all", 1'b0, 1'b1, 1, 9'h1FF, 9'h000, 9'h000, 9'h000, 8'h25, 3'd0,
                1'b0, 1'b0, 1'b0, 8'h00, 1'b0, 3'd0);            // Level 0 outranks level 5
        add_row("nest_2_over_5", 1'b0, 1'b1, 1, 9'h100, 9'h000, 9'h000, 9'h000, 8'h24, 3'd0,
                1'b1, 1'b1, 1'b1, 8'h42, 1'b0, 3'd0);            // 2 outranks 5 in service
        add_row("nest_5_blocked", 1'b0, 1'b1, 0, 9'h000, 9'h000, 9'h000, 9'h000, 8'h20, 3'd0,
                1'b0, 1'b0, 1'b0, 8'h00, 1'b0, 3'd0);
        add_row("eoi_nonspecific", 1'b0, 1'b1, 1, nseoi, 9'h000, 9'h000, 9'h000, 8'h24, 3'd0,
                1'b1, 1'b1, 1'b1, 8'h42, 1'b0, 3'd0);            // Clears 2, then 2 again
        add_row("eoi_specific", 1'b0, 1'b1, 2, seoi5, seoi2, 9'h000, 9'h000, 8'h20, 3'd0,
                1'b1, 1'b1, 1'b1, 8'h45, 1'b0, 3'd0);            // ISR empty before ack
        add_row("cascade_master", 1'b1, 1'b1, 3, icw1, icw2, 9'h108, 9'h000, 8'h08, 3'd0,
                1'b1, 1'b1, 1'b0, 8'h00, 1'b1, 3'd3);
        add_row("slave_id_mismatch", 1'b1, 1'b0, 3, icw1, icw2, 9'h104, 9'h000, 8'h10, 3'd6,
                1'b1, 1'b1, 1'b0, 8'h00, 1'b0, 3'd0);
        add_row("slave_still_req", 1'b0, 1'b0, 0, 9'h000, 9'h000, 9'h000, 9'h000, 8'h10, 3'd6,
                1'b0, 1'b1, 1'b0, 8'h00, 1'b0, 3'd0);            // Nothing was committed
        add_row("slave_id_match", 1'b0, 1'b0, 0, 9'h000, 9'h000, 9'h000, 9'h000, 8'h10, 3'd4,
                1'b1, 1'b1, 1'b1, 8'h44, 1'b0, 3'd0);
        add_row("init_before_icw1", 1'b1, 1'b1, 0, 9'h000, 9'h000, 9'h000, 9'h000, 8'hFF, 3'd0,
                1'b0, 1'b0, 1'b0, 8'h00, 1'b0, 3'd0);
        add_row("init_complete", 1'b0, 1'b1, 3, icw1, icw2, 9'h100, 9'h000, 8'hFF, 3'd0,
                1'b1, 1'b1, 1'b1, 8'h40, 1'b0, 3'd0);
        add_row("init_restart", 1'b0, 1'b1, 2, nseoi, icw1, 9'h000, 9'h000, 8'hFF, 3'd0,
                1'b0, 1'b0, 1'b0, 8'h00, 1'b0, 3'd0);            // Level 0 retired, back in init
    endtask

    task automatic hold_reset();
        @(posedge control_signal) reset <= 1'b1;
        repeat (4) @(posedge control_signal);
        reset <= 1'b0;
    endtask

    task automatic bus_write(input logic [8:0] entry);
        @(posedge control_signal);
        wr      <= 1'b1;
        a0      <= entry[8];
        data_in <= entry[7:0];
        @(posedge control_signal) wr <= 1'b0;
    endtask

    task automatic run_row(input int r);
        @(posedge control_signal);
        cur_name <= t_name[r];
        sp       <= t_sp[r];
        cas_in   <= t_cas_in[r];
        exp_irq  <= t_irq[r];
        exp_vv   <= t_vv[r];
        exp_vec  <= t_vec[r];
        exp_oe   <= t_oe[r];
        exp_cas  <= t_cas[r];
        if (t_rst[r]) hold_reset();
        for (int w = 0; w < t_nwr[r]; w++) bus_write(t_wr[r][w]);
        @(posedge control_signal) ir <= t_ir[r];
        @(posedge control_signal);                               // irr stage
        @(posedge control_signal) chk_irq <= 1'b1;               // int_req stage done
        @(posedge control_signal) chk_irq <= 1'b0;
        if (t_ack[r]) begin
            inta <= 1'b1;                                        // First pulse
            @(posedge control_signal) inta <= 1'b0;
            @(posedge control_signal);
            inta    <= 1'b1;                                     // Second pulse
            chk_mid <= 1'b1;                                     // Cascade lines between pulses
            @(posedge control_signal);
            inta    <= 1'b0;
            chk_mid <= 1'b0;
            chk_vec <= 1'b1;                                     // Vector strobe next cycle
            @(posedge control_signal) chk_vec <= 1'b0;
        end
        row_done <= 1'b1;
        @(posedge control_signal) row_done <= 1'b0;
    endtask

    initial begin
        reset    = 1'b1;
        sp       = 1'b1;
        wr       = 1'b0;
        a0       = 1'b0;
        data_in  = '0;
        ir       = '0;
        inta     = 1'b0;
        cas_in   = '0;
        cur_name = "reset";
        chk_irq  = 1'b0;
        chk_mid  = 1'b0;
        chk_vec  = 1'b0;
        row_done = 1'b0;
        exp_irq  = 1'b0;
        exp_vv   = 1'b0;
        exp_vec  = '0;
        exp_oe   = 1'b0;
        exp_cas  = '0;
        load_table();
        repeat (4) @(posedge control_signal);
        reset <= 1'b0;
        for (int r = 0; r < row_count; r++) run_row(r);
        @(posedge control_signal);
        $display("%0d checks, %0d failures", check_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Ends a stuck run
    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns before all rows finished", watchdog_ns);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: files.f
hw/pic_pkg.sv
hw/pic_config_regs.sv
hw/pic_priority_resolver.sv
hw/pic_cascade_controller.sv
hw/pic_ack_sequencer.sv
hw/pic_top.sv
verif/pic_checker.sv
verif/pic_tb.sv

// File: Makefile
# Verilator build and run for the PIC testbench

TOP = pic_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f files.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir
